// File: verilog/rob_pkg.sv
// reorder buffer package: sizes, reset tag and the structs shared by every block
package rob_pkg;

	////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////

	localparam int ROB_DEPTH = 16;                  // power of two, pointers wrap
	localparam int ROB_IDX_W = $clog2(ROB_DEPTH);
	localparam int ROB_CNT_W = ROB_IDX_W + 1;        // occupancy holds 0..ROB_DEPTH

	localparam int PREG_W = 7;                      // physical register tag
	localparam int AREG_W = 5;                      // architectural register
	localparam int ADDR_W = 64;                     // branch target

	localparam int CDB_PORTS = 4;
	localparam int CDB_RESULT_PORTS = 2;            // only these carry exception and branch data

	// tag of an empty entry, never handed out by the free list
	localparam logic [PREG_W-1:0] NO_TAG = '1;

	////////////////////////////////////////////////////////////
	// structs
	////////////////////////////////////////////////////////////

	// one instruction from dispatch
	typedef struct packed {
		logic              valid_inst;     // low means invalid instruction, ready at once
		logic              halt;
		logic              uncond_branch;
		logic              wr_mem;         // store
		logic [AREG_W-1:0] ar;
		logic [PREG_W-1:0] tag;            // new physical tag
		logic [PREG_W-1:0] told;           // previous mapping of ar
	} dispatch_slot_t;

	// one common data bus port
	typedef struct packed {
		logic              strobe;
		logic [PREG_W-1:0] tag;
		logic              exception;
		logic              taken;
		logic [ADDR_W-1:0] target;
	} cdb_port_t;

	// one retiring entry, for map table, free list and store queue
	typedef struct packed {
		logic [AREG_W-1:0] ar;
		logic [PREG_W-1:0] tag;
		logic [PREG_W-1:0] told;
		logic              wr_mem;
		logic              uncond_branch;
		logic              taken;
		logic [ADDR_W-1:0] target;
	} retire_slot_t;

endpackage

// File: verilog/rob_pointers.sv
// reorder buffer pointers: head, tail, occupancy and the capacity report to dispatch
module rob_pointers
(
	input  logic                           clock,
	input  logic                           reset,
	input  logic [1:0]                     dispatch_num,
	input  logic [1:0]                     retire_num,
	output logic [rob_pkg::ROB_IDX_W-1:0] head,
	output logic [rob_pkg::ROB_IDX_W-1:0] head_next,
	output logic [rob_pkg::ROB_IDX_W-1:0] tail,
	output logic [rob_pkg::ROB_IDX_W-1:0] tail_next,
	output logic [1:0]                     dispatch_cap
);

	logic [rob_pkg::ROB_CNT_W-1:0] count;     // valid entries between head and tail
	logic [rob_pkg::ROB_CNT_W-1:0] free_cnt;

	////////////////////////////////////////////////////////////
	// pointer and occupancy registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end
		else
		begin
			// depth is a power of two so the adds wrap by themselves
			head  <= head + rob_pkg::ROB_IDX_W'(retire_num);
			tail  <= tail + rob_pkg::ROB_IDX_W'(dispatch_num);
			count <= count + rob_pkg::ROB_CNT_W'(dispatch_num)
				- rob_pkg::ROB_CNT_W'(retire_num);
		end
	end

	// second slot of each pair
	assign head_next = head + rob_pkg::ROB_IDX_W'(1);
	assign tail_next = tail + rob_pkg::ROB_IDX_W'(1);

	////////////////////////////////////////////////////////////
	// capacity
	////////////////////////////////////////////////////////////

	assign free_cnt = rob_pkg::ROB_CNT_W'(rob_pkg::ROB_DEPTH) - count;

	always_comb
	begin
		if (free_cnt == '0)
		begin
			dispatch_cap = 2'd0;           // full
		end
		else if (free_cnt == rob_pkg::ROB_CNT_W'(1))
		begin
			dispatch_cap = 2'd1;           // almost full
		end
		else
		begin
			dispatch_cap = 2'd2;
		end
	end

endmodule

// File: verilog/rob_completion.sv
// reorder buffer completion: matches bus tags against stored tags and merges the results
module rob_completion
(
	input  rob_pkg::cdb_port_t [rob_pkg::CDB_PORTS-1:0]               cdb,
	input  logic [rob_pkg::ROB_DEPTH-1:0][rob_pkg::PREG_W-1:0]        entry_tag,
	input  logic [rob_pkg::ROB_DEPTH-1:0]                             entry_valid,
	output logic [rob_pkg::ROB_DEPTH-1:0]                             hit,
	output logic [rob_pkg::ROB_DEPTH-1:0]                             hit_exception,
	output logic [rob_pkg::ROB_DEPTH-1:0]                             hit_taken,
	output logic [rob_pkg::ROB_DEPTH-1:0][rob_pkg::ADDR_W-1:0]        hit_target
);

	// one bit per entry and port
	logic [rob_pkg::ROB_DEPTH-1:0][rob_pkg::CDB_PORTS-1:0] match;

	////////////////////////////////////////////////////////////
	// tag compare
	////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int e = 0; e < rob_pkg::ROB_DEPTH; e++)
		begin
			for (int p = 0; p < rob_pkg::CDB_PORTS; p++)
			begin
				// empty entries hold NO_TAG but must never match
				match[e][p] = cdb[p].strobe && entry_valid[e]
					&& (cdb[p].tag == entry_tag[e]);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// result select
	////////////////////////////////////////////////////////////

	always_comb
	begin
		hit           = '0;
		hit_exception = '0;
		hit_taken     = '0;
		hit_target    = '0;
		for (int e = 0; e < rob_pkg::ROB_DEPTH; e++)
		begin
			// later ports overwrite, so the highest matching port wins
			for (int p = 0; p < rob_pkg::CDB_PORTS; p++)
			begin
				if (match[e][p])
				begin
					hit[e] = 1'b1;
					if (p < rob_pkg::CDB_RESULT_PORTS)
					begin
						hit_exception[e] = cdb[p].exception;
						hit_taken[e]     = cdb[p].taken;
						hit_target[e]    = cdb[p].target;
					end
					else
					begin
						hit_exception[e] = 1'b0;   // plain ALU ports carry no outcome
						hit_taken[e]     = 1'b0;
						hit_target[e]    = '0;
					end
				end
			end
		end
	end

endmodule

// File: verilog/rob_entry_store.sv
// reorder buffer entry store: dispatch writes, completion updates, retire clears, head reads
module rob_entry_store
(
	input  logic                                                   clock,
	input  logic                                                   reset,

	input  logic [1:0]                                             dispatch_num,
	input  rob_pkg::dispatch_slot_t [1:0]                          dispatch_slot,

	input  logic [rob_pkg::ROB_IDX_W-1:0]                          head,
	input  logic [rob_pkg::ROB_IDX_W-1:0]                          head_next,
	input  logic [rob_pkg::ROB_IDX_W-1:0]                          tail,
	input  logic [rob_pkg::ROB_IDX_W-1:0]                          tail_next,

	input  logic [rob_pkg::ROB_DEPTH-1:0]                          hit,
	input  logic [rob_pkg::ROB_DEPTH-1:0]                          hit_exception,
	input  logic [rob_pkg::ROB_DEPTH-1:0]                          hit_taken,
	input  logic [rob_pkg::ROB_DEPTH-1:0][rob_pkg::ADDR_W-1:0]     hit_target,

	input  logic [1:0]                                             retire_num,

	output logic [rob_pkg::ROB_DEPTH-1:0][rob_pkg::PREG_W-1:0]     entry_tag,
	output logic [rob_pkg::ROB_DEPTH-1:0]                          entry_valid,

	output logic [1:0]                                             head_ready,
	output logic [1:0]                                             head_exception,
	output logic [1:0]                                             head_wr_mem,
	output logic [1:0]                                             head_halt,
	output rob_pkg::retire_slot_t [1:0]                            retire_slot
);

	// control state
	logic [rob_pkg::ROB_DEPTH-1:0]                         valid;
	logic [rob_pkg::ROB_DEPTH-1:0]                         ready;
	logic [rob_pkg::ROB_DEPTH-1:0]                         exception;
	logic [rob_pkg::ROB_DEPTH-1:0][rob_pkg::PREG_W-1:0]    tag;

	// payload
	logic [rob_pkg::ROB_DEPTH-1:0]                         taken;
	logic [rob_pkg::ROB_DEPTH-1:0]                         halt;
	logic [rob_pkg::ROB_DEPTH-1:0]                         wr_mem;
	logic [rob_pkg::ROB_DEPTH-1:0]                         uncond_branch;
	logic [rob_pkg::ROB_DEPTH-1:0][rob_pkg::AREG_W-1:0]    ar;
	logic [rob_pkg::ROB_DEPTH-1:0][rob_pkg::PREG_W-1:0]    told;
	logic [rob_pkg::ROB_DEPTH-1:0][rob_pkg::ADDR_W-1:0]    target;

	logic disp0;
	logic disp1;
	logic ret0;
	logic ret1;

	assign disp0 = (dispatch_num != 2'd0);
	assign disp1 = dispatch_num[1];
	assign ret0  = (retire_num != 2'd0);
	assign ret1  = retire_num[1];

	////////////////////////////////////////////////////////////
	// control state: completion, then retire, then dispatch
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid     <= '0;
			ready     <= '0;
			exception <= '0;
			for (int i = 0; i < rob_pkg::ROB_DEPTH; i++)
			begin
				tag[i] <= rob_pkg::NO_TAG;
			end
		end
		else
		begin
			for (int i = 0; i < rob_pkg::ROB_DEPTH; i++)
			begin
				if (hit[i])
				begin
					ready[i]     <= 1'b1;
					exception[i] <= hit_exception[i];
				end
			end
			// both retiring slots give their tag back
			if (ret0)
			begin
				valid[head] <= 1'b0;
				ready[head] <= 1'b0;
				tag[head]   <= rob_pkg::NO_TAG;
			end
			if (ret1)
			begin
				valid[head_next] <= 1'b0;
				ready[head_next] <= 1'b0;
				tag[head_next]   <= rob_pkg::NO_TAG;
			end
			// halt and invalid instructions need no completion
			if (disp0)
			begin
				valid[tail]     <= 1'b1;
				ready[tail]     <= ~dispatch_slot[0].valid_inst | dispatch_slot[0].halt;
				exception[tail] <= 1'b0;
				tag[tail]       <= dispatch_slot[0].tag;
			end
			if (disp1)
			begin
				valid[tail_next]     <= 1'b1;
				ready[tail_next]     <= ~dispatch_slot[1].valid_inst | dispatch_slot[1].halt;
				exception[tail_next] <= 1'b0;
				tag[tail_next]       <= dispatch_slot[1].tag;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// payload
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		for (int i = 0; i < rob_pkg::ROB_DEPTH; i++)
		begin
			if (hit[i])
			begin
				taken[i]  <= hit_taken[i];
				target[i] <= hit_target[i];
			end
		end
		if (disp0)
		begin
			taken[tail]         <= 1'b0;              // cleared for entries that never complete
			target[tail]        <= '0;
			halt[tail]          <= dispatch_slot[0].halt;
			wr_mem[tail]        <= dispatch_slot[0].wr_mem;
			uncond_branch[tail] <= dispatch_slot[0].uncond_branch;
			ar[tail]            <= dispatch_slot[0].ar;
			told[tail]          <= dispatch_slot[0].told;
		end
		if (disp1)
		begin
			taken[tail_next]         <= 1'b0;
			target[tail_next]        <= '0;
			halt[tail_next]          <= dispatch_slot[1].halt;
			wr_mem[tail_next]        <= dispatch_slot[1].wr_mem;
			uncond_branch[tail_next] <= dispatch_slot[1].uncond_branch;
			ar[tail_next]            <= dispatch_slot[1].ar;
			told[tail_next]          <= dispatch_slot[1].told;
		end
	end

	////////////////////////////////////////////////////////////
	// reads for completion and retire
	////////////////////////////////////////////////////////////

	assign entry_tag   = tag;
	assign entry_valid = valid;

	assign head_ready     = {ready[head_next], ready[head]};
	assign head_exception = {exception[head_next], exception[head]};
	assign head_wr_mem    = {wr_mem[head_next], wr_mem[head]};
	assign head_halt      = {halt[head_next], halt[head]};

	always_comb
	begin
		retire_slot[0].ar            = ar[head];
		retire_slot[0].tag           = tag[head];
		retire_slot[0].told          = told[head];
		retire_slot[0].wr_mem        = wr_mem[head];
		retire_slot[0].uncond_branch = uncond_branch[head];
		retire_slot[0].taken         = taken[head];
		retire_slot[0].target        = target[head];

		retire_slot[1].ar            = ar[head_next];
		retire_slot[1].tag           = tag[head_next];
		retire_slot[1].told          = told[head_next];
		retire_slot[1].wr_mem        = wr_mem[head_next];
		retire_slot[1].uncond_branch = uncond_branch[head_next];
		retire_slot[1].taken         = taken[head_next];
		retire_slot[1].target        = target[head_next];
	end

endmodule

// File: verilog/rob_retire.sv
// reorder buffer retire logic: retire count plus the exception and halt pulses
module rob_retire
(
	input  logic [1:0] head_ready,       // bit 0 is the head, bit 1 the entry behind it
	input  logic [1:0] head_exception,
	input  logic [1:0] head_wr_mem,
	input  logic [1:0] head_halt,
	output logic [1:0] retire_num,
	output logic       recover_exception,
	output logic       retire_halt
);

	logic both_ready;
	logic store_pair;      // store queue takes one store per cycle
	logic retire_two;
	logic slot0_out;
	logic slot1_out;

	////////////////////////////////////////////////////////////
	// retire count
	////////////////////////////////////////////////////////////

	assign both_ready = head_ready[0] & head_ready[1];
	assign store_pair = head_wr_mem[0] & head_wr_mem[1];

	// an excepting head retires alone so recovery sees it first
	assign retire_two = both_ready & ~head_exception[0] & ~store_pair;

	always_comb
	begin
		if (retire_two)
		begin
			retire_num = 2'd2;
		end
		else if (head_ready[0])
		begin
			retire_num = 2'd1;
		end
		else
		begin
			retire_num = 2'd0;
		end
	end

	////////////////////////////////////////////////////////////
	// pulses
	////////////////////////////////////////////////////////////

	assign slot0_out = (retire_num != 2'd0);
	assign slot1_out = retire_num[1];

	assign recover_exception = (slot0_out & head_exception[0])
		| (slot1_out & head_exception[1]);

	assign retire_halt = (slot0_out & head_halt[0]) | (slot1_out & head_halt[1]);

endmodule

// File: verilog/rob_top.sv
// two-wide reorder buffer top level, connecting pointers, store, completion and retire
module rob_top
(
	input  logic                                            clock,
	input  logic                                            reset,

	input  logic [1:0]                                      dispatch_num,
	input  rob_pkg::dispatch_slot_t [1:0]                   dispatch_slot,
	input  rob_pkg::cdb_port_t [rob_pkg::CDB_PORTS-1:0]     cdb,

	output logic [1:0]                                      dispatch_cap,
	output logic [1:0]                                      retire_num,
	output rob_pkg::retire_slot_t [1:0]                     retire_slot,
	output logic                                            recover_exception,
	output logic                                            retire_halt
);

	logic [rob_pkg::ROB_IDX_W-1:0]                         head;
	logic [rob_pkg::ROB_IDX_W-1:0]                         head_next;
	logic [rob_pkg::ROB_IDX_W-1:0]                         tail;
	logic [rob_pkg::ROB_IDX_W-1:0]                         tail_next;

	logic [rob_pkg::ROB_DEPTH-1:0][rob_pkg::PREG_W-1:0]    entry_tag;
	logic [rob_pkg::ROB_DEPTH-1:0]                         entry_valid;
	logic [rob_pkg::ROB_DEPTH-1:0]                         hit;
	logic [rob_pkg::ROB_DEPTH-1:0]                         hit_exception;
	logic [rob_pkg::ROB_DEPTH-1:0]                         hit_taken;
	logic [rob_pkg::ROB_DEPTH-1:0][rob_pkg::ADDR_W-1:0]    hit_target;

	logic [1:0]                                            head_ready;
	logic [1:0]                                            head_exception;
	logic [1:0]                                            head_wr_mem;
	logic [1:0]                                            head_halt;

	rob_pointers pointers0
	(
		.clock        (clock),
		.reset        (reset),
		.dispatch_num (dispatch_num),
		.retire_num   (retire_num),
		.head         (head),
		.head_next    (head_next),
		.tail         (tail),
		.tail_next    (tail_next),
		.dispatch_cap (dispatch_cap)
	);

	rob_completion completion0
	(
		.cdb           (cdb),
		.entry_tag     (entry_tag),
		.entry_valid   (entry_valid),
		.hit           (hit),
		.hit_exception (hit_exception),
		.hit_taken     (hit_taken),
		.hit_target    (hit_target)
	);

	rob_entry_store store0
	(
		.clock          (clock),
		.reset          (reset),
		.dispatch_num   (dispatch_num),
		.dispatch_slot  (dispatch_slot),
		.head           (head),
		.head_next      (head_next),
		.tail           (tail),
		.tail_next      (tail_next),
		.hit            (hit),
		.hit_exception  (hit_exception),
		.hit_taken      (hit_taken),
		.hit_target     (hit_target),
		.retire_num     (retire_num),
		.entry_tag      (entry_tag),
		.entry_valid    (entry_valid),
		.head_ready     (head_ready),
		.head_exception (head_exception),
		.head_wr_mem    (head_wr_mem),
		.head_halt      (head_halt),
		.retire_slot    (retire_slot)
	);

	rob_retire retire0
	(
		.head_ready        (head_ready),
		.head_exception    (head_exception),
		.head_wr_mem       (head_wr_mem),
		.head_halt         (head_halt),
		.retire_num        (retire_num),
		.recover_exception (recover_exception),
		.retire_halt       (retire_halt)
	);

endmodule

// File: dv/rob_tb_model.svh
// reorder buffer reference model: a queue of expected entries in dispatch order

typedef struct packed {
	rob_pkg::dispatch_slot_t    slot;
	logic                       ready;
	logic                       exception;
	logic                       taken;
	logic [rob_pkg::ADDR_W-1:0] target;
} exp_entry_t;

exp_entry_t rob_q[$];           // index 0 is the oldest entry
logic       head_hit = 1'b0;    // new head was completed at the last edge

// two leave together only when both are ready, the head is clean and not two stores
function automatic logic [1:0] retire_count_rule();
	if (rob_q.size() == 0)
	begin
		return 2'd0;
	end
	if (!rob_q[0].ready)
	begin
		return 2'd0;
	end
	if (rob_q.size() > 1 && rob_q[1].ready && !rob_q[0].exception
		&& !(rob_q[0].slot.wr_mem && rob_q[1].slot.wr_mem))
	begin
		return 2'd2;
	end
	return 2'd1;
endfunction

function automatic logic [1:0] cap_from_occupancy();
	int free_slots;
	free_slots = rob_pkg::ROB_DEPTH - rob_q.size();
	if (free_slots == 0)
	begin
		return 2'd0;
	end
	else if (free_slots == 1)
	begin
		return 2'd1;
	end
	return 2'd2;
endfunction

////////////////////////////////////////////////////////////
// one clock edge: completion, retire, dispatch
////////////////////////////////////////////////////////////

task automatic model_step(input logic [1:0] num,
	input rob_pkg::dispatch_slot_t [1:0] slots,
	input rob_pkg::cdb_port_t [rob_pkg::CDB_PORTS-1:0] ports);
	int         n_ret;
	exp_entry_t e;
	n_ret    = retire_count_rule();   // decided on the state before the edge
	head_hit = 1'b0;
	for (int i = 0; i < rob_q.size(); i++)
	begin
		e = rob_q[i];
		for (int p = 0; p < rob_pkg::CDB_PORTS; p++)
		begin
			// ascending loop, so the highest port wins
			if (ports[p].strobe && ports[p].tag == e.slot.tag)
			begin
				e.ready = 1'b1;
				if (p < rob_pkg::CDB_RESULT_PORTS)
				begin
					e.exception = ports[p].exception;
					e.taken     = ports[p].taken;
					e.target    = ports[p].target;
				end
				else
				begin
					e.exception = 1'b0;
					e.taken     = 1'b0;
					e.target    = '0;
				end
				if (i == n_ret)
				begin
					head_hit = 1'b1;   // becomes the head after this edge
				end
			end
		end
		rob_q[i] = e;
	end
	repeat (n_ret)
	begin
		void'(rob_q.pop_front());
	end
	for (int s = 0; s < num; s++)
	begin
		e           = '0;
		e.slot      = slots[s];
		e.ready     = !slots[s].valid_inst || slots[s].halt;
		rob_q.push_back(e);
	end
endtask

// File: dv/rob_tb.sv
// reorder buffer testbench: random dispatch and completion checked against a queue model
module rob_tb;

	localparam int NUM_CYCLES = 2000;

	logic                                          clock;
	logic                                          reset;
	logic [1:0]                                    dispatch_num;
	rob_pkg::dispatch_slot_t [1:0]                 dispatch_slot;
	rob_pkg::cdb_port_t [rob_pkg::CDB_PORTS-1:0]   cdb;
	logic [1:0]                                    dispatch_cap;
	logic [1:0]                                    retire_num;
	rob_pkg::retire_slot_t [1:0]                   retire_slot;
	logic                                          recover_exception;
	logic                                          retire_halt;

	int          errors = 0;
	int          checks = 0;
	int          next_tag = 0;
	logic [15:0] lfsr = 16'd82;
	logic        saw_full = 1'b0;
	logic        saw_halt = 1'b0;

	`include "rob_tb_model.svh"

	rob_top dut0
	(
		.clock             (clock),
		.reset             (reset),
		.dispatch_num      (dispatch_num),
		.dispatch_slot     (dispatch_slot),
		.cdb               (cdb),
		.dispatch_cap      (dispatch_cap),
		.retire_num        (retire_num),
		.retire_slot       (retire_slot),
		.recover_exception (recover_exception),
		.retire_halt       (retire_halt)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// galois lfsr, one step per bit
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			bits = {bits[62:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return bits;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] want);
		checks++;
		assert (got === want)
		else
		begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h at %0t", name, got, want, $time);
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	task automatic choose_inputs(input int cyc);
		logic                                        burst;
		logic [1:0]                                  num;
		logic [3:0]                                  kind;
		int                                          pend[$];
		rob_pkg::dispatch_slot_t [1:0]               slots;
		rob_pkg::cdb_port_t [rob_pkg::CDB_PORTS-1:0] ports;
		burst = (cyc % 200) < 30;      // fill without completions
		num   = burst ? 2'd2 : 2'(rand_bits(2));
		if (num == 2'd3)
		begin
			num = 2'd1;
		end
		if (num > cap_from_occupancy())
		begin
			num = cap_from_occupancy();
		end
		slots = '0;
		for (int s = 0; s < 2; s++)
		begin
			kind                   = 4'(rand_bits(4));
			slots[s].valid_inst    = burst || kind != 4'd0;
			slots[s].halt          = !burst && kind == 4'd1;
			slots[s].wr_mem        = rand_bits(1);
			slots[s].uncond_branch = rand_bits(2) == 0;
			slots[s].ar            = rand_bits(rob_pkg::AREG_W);
			slots[s].told          = rand_bits(rob_pkg::PREG_W);
			if (s < num)
			begin
				slots[s].tag = next_tag;
				next_tag     = (next_tag == 126) ? 0 : next_tag + 1;   // skips NO_TAG
			end
		end
		for (int i = 0; i < rob_q.size(); i++)
		begin
			if (!rob_q[i].ready)
			begin
				pend.push_back(i);
			end
		end
		for (int p = 0; p < rob_pkg::CDB_PORTS; p++)
		begin
			ports[p].strobe    = !burst && pend.size() > 0 && rand_bits(1);
			ports[p].tag       = rand_bits(rob_pkg::PREG_W);
			if (ports[p].strobe)
			begin
				ports[p].tag = rob_q[pend[rand_bits(4) % pend.size()]].slot.tag;
			end
			ports[p].exception = rand_bits(3) == 0;
			ports[p].taken     = rand_bits(1);
			ports[p].target    = rand_bits(rob_pkg::ADDR_W);
		end
		dispatch_num  <= num;
		dispatch_slot <= slots;
		cdb           <= ports;
	endtask

	////////////////////////////////////////////////////////////
	// checks, sampled mid cycle
	////////////////////////////////////////////////////////////

	task automatic check_outputs();
		logic [1:0] n;
		logic       exc;
		logic       hlt;
		n   = retire_count_rule();
		exc = 1'b0;
		hlt = 1'b0;
		check_value("dispatch_cap", dispatch_cap, cap_from_occupancy());
		check_value("retire_num", retire_num, n);
		for (int s = 0; s < n; s++)
		begin
			check_value($sformatf("retire_slot[%0d].ar", s), retire_slot[s].ar,
				rob_q[s].slot.ar);
			check_value($sformatf("retire_slot[%0d].tag", s), retire_slot[s].tag,
				rob_q[s].slot.tag);
			check_value($sformatf("retire_slot[%0d].told", s), retire_slot[s].told,
				rob_q[s].slot.told);
			check_value($sformatf("retire_slot[%0d].wr_mem", s), retire_slot[s].wr_mem,
				rob_q[s].slot.wr_mem);
			check_value($sformatf("retire_slot[%0d].uncond_branch", s),
				retire_slot[s].uncond_branch, rob_q[s].slot.uncond_branch);
			check_value($sformatf("retire_slot[%0d].taken", s), retire_slot[s].taken,
				rob_q[s].taken);
			check_value($sformatf("retire_slot[%0d].target", s), retire_slot[s].target,
				rob_q[s].target);
			exc = exc | rob_q[s].exception;
			hlt = hlt | rob_q[s].slot.halt;
		end
		check_value("recover_exception", recover_exception, exc);
		check_value("retire_halt", retire_halt, hlt);
		assert (!head_hit || retire_num != 2'd0)
		else
		begin
			errors++;
			$display("completed head entry did not retire in the next cycle at %0t", $time);
		end
		saw_full = saw_full | (cap_from_occupancy() == 2'd0);
		saw_halt = saw_halt | hlt;
	endtask

	initial
	begin
		reset         <= 1'b1;
		dispatch_num  <= 2'd0;
		dispatch_slot <= '0;
		cdb           <= '0;
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		for (int cyc = 0; cyc < NUM_CYCLES; cyc++)
		begin
			@(negedge clock);
			check_outputs();
			@(posedge clock);
			model_step(dispatch_num, dispatch_slot, cdb);   // inputs of the cycle just ended
			choose_inputs(cyc);
		end
		assert (saw_full && saw_halt)
		else
		begin
			errors++;
			$display("stimulus never filled the buffer or never retired a halt");
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
		begin
			$display("Finished with no errors");
		end
		else
		begin
			$display("Finished with errors");
		end
		$finish;
	end

	// watchdog
	initial
	begin
		#((NUM_CYCLES + 200) * 10);
		$display("simulation timed out after %0d errors", errors);
		$display("Finished with errors");
		$finish;
	end

endmodule

// File: build.f
+incdir+dv
verilog/rob_pkg.sv
verilog/rob_pointers.sv
verilog/rob_completion.sv
verilog/rob_entry_store.sv
verilog/rob_retire.sv
verilog/rob_top.sv
dv/rob_tb.sv
